// ==== vlog.f ====
cimPkg.sv
cimColumn.sv
rowDriver.sv
adcDecode.sv
cimSequencer.sv
cimTop.sv
cimTop_chk.sv
cimTb.sv

// ==== Makefile ====
# Verilator build and run of the compute-in-memory column testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= cimTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, log in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	@./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== cimTb.sv ====
// Testbench for the compute-in-memory column top level
// Runs a table of write, read and MAC commands through the host ports,
// predicts each response from a shadow copy of the array and checks it
// A watchdog stops the run if the table does not finish in time

`timescale 1ns/1ps
`default_nettype none

module cimTb import cimPkg::*; ();

    localparam int numRows = 16;
    localparam int numCols = 8;
    localparam int numAdcBits = 4;
    localparam int addrBits = $clog2(numRows);
    localparam int codeMax = 2**(numAdcBits-1) - 1;
    localparam int codeMin = -(2**(numAdcBits-1));

    typedef rowDrive [numRows-1:0] driveVec;
    typedef enum {dataNone, dataRandom, dataUniform} dataKind;
    typedef enum {patZero, patRandom, patMatch, patOpposite} drivePat;
    typedef enum {expAck, expWord, expMac} expKind;

    // One table row, stall is the number of cycles rspReady stays low
    typedef struct {
        cimOp op;
        logic [addrBits-1:0] addr;
        dataKind data;
        drivePat pat;
        expKind exp;
        int stall;
    } stimEntry;

    logic CLK;
    logic rstN;
    logic reqValid;
    logic reqReady;
    cimOp reqOp;
    logic [addrBits-1:0] reqAddr;
    logic [numCols-1:0] reqData;
    driveVec reqDrive;
    logic rspValid;
    logic rspReady;
    cimOp rspOp;
    logic [numCols-1:0] rspData;
    logic [numCols-1:0][numAdcBits-1:0] rspMac;

    stimEntry stimTable[$];
    logic [numCols-1:0] shadow [numRows];
    logic [15:0] lfsrState;
    int errors;
    int testsRun;
    int testsFailed;
    bit tableBuilt;

    cimTop dut (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic void addEntry(input cimOp op, input int addr, input dataKind dk,
                                     input drivePat pat, input expKind ek, input int stall);
        stimEntry e;
        e.op = op;
        e.addr = addr[addrBits-1:0];
        e.data = dk;
        e.pat = pat;
        e.exp = ek;
        e.stall = stall;
        stimTable.push_back(e);
    endfunction

    function automatic void buildTable();
        // Fill the array, then read every row back
        for (int i = 0; i < numRows; i++) begin
            addEntry(opWrite, i, dataRandom, patZero, expAck, 0);
        end
        for (int i = 0; i < numRows; i++) begin
            addEntry(opRead, i, dataNone, patZero, expWord, (i == 5) ? 6 : 0);
        end
        // Random ternary inputs, one of them under back-pressure
        for (int i = 0; i < 6; i++) begin
            addEntry(opMac, 0, dataNone, patRandom, expMac, (i == 2) ? 5 : 0);
        end
        addEntry(opMac, 0, dataNone, patZero, expMac, 0);
        // Uniform rows so every column sees the same weight per row
        for (int i = 0; i < numRows; i++) begin
            addEntry(opWrite, i, dataUniform, patZero, expAck, 0);
        end
        addEntry(opMac, 0, dataNone, patMatch, expMac, 0);
        addEntry(opMac, 0, dataNone, patOpposite, expMac, 4);
    endfunction

    function automatic driveVec makeDrive(input drivePat pat);
        driveVec d;
        logic [31:0] r;
        for (int i = 0; i < numRows; i++) begin
            case (pat)
                patRandom: begin
                    r = randBits(2);
                    case (r[1:0])
                        2'd1:    d[i] = drivePos;
                        2'd2:    d[i] = driveNeg;
                        default: d[i] = driveZero;
                    endcase
                end
                // Column 0 weight decides the sign, rows are uniform here
                patMatch:    d[i] = shadow[i][0] ? drivePos : driveNeg;
                patOpposite: d[i] = shadow[i][0] ? driveNeg : drivePos;
                default:     d[i] = driveZero;
            endcase
        end
        return d;
    endfunction

    // Weight bit 1 is +1 and bit 0 is -1, input is +1, -1 or 0
    function automatic int expectedMac(input driveVec drv, input int col);
        int sum;
        int w;
        int x;
        sum = 0;
        for (int i = 0; i < numRows; i++) begin
            w = shadow[i][col] ? 1 : -1;
            x = (drv[i] == drivePos) ? 1 : ((drv[i] == driveNeg) ? -1 : 0);
            sum = sum + w * x;
        end
        if (sum > codeMax) begin
            sum = codeMax;
        end else if (sum < codeMin) begin
            sum = codeMin;
        end
        return sum;
    endfunction

    function automatic void reportMismatch(input string name, input int expV, input int gotV);
        errors++;
        $display("Fail t=%0t %s expected %0d got %0d", $time, name, expV, gotV);
    endfunction

    task automatic runEntry(input int idx);
        stimEntry e;
        cimOp curOp;
        logic [31:0] r;
        logic [numCols-1:0] wrWord;
        logic [numCols-1:0] expData;
        driveVec drv;
        int expCode [numCols];
        int got;
        int errBefore;
        cimOp heldOp;
        logic [numCols-1:0] heldData;
        logic [numCols-1:0][numAdcBits-1:0] heldMac;

        e = stimTable[idx];
        curOp = e.op;
        errBefore = errors;
        wrWord = '0;
        if (e.data == dataRandom) begin
            r = randBits(numCols);
            wrWord = r[numCols-1:0];
        end else if (e.data == dataUniform) begin
            r = randBits(1);
            wrWord = r[0] ? '1 : '0;
        end
        drv = makeDrive(e.pat);

        // Predict from the shadow array
        if (e.op == opWrite) begin
            shadow[e.addr] = wrWord;
        end
        expData = shadow[e.addr];
        for (int j = 0; j < numCols; j++) begin
            expCode[j] = expectedMac(drv, j);
        end

        @(posedge CLK);
        reqValid <= 1'b1;
        reqOp <= e.op;
        reqAddr <= e.addr;
        reqData <= wrWord;
        reqDrive <= drv;
        rspReady <= (e.stall == 0);

        // Request transfers on the first edge that finds reqReady high
        do begin
            @(negedge CLK);
        end while (!reqReady);
        @(posedge CLK);
        reqValid <= 1'b0;

        do begin
            @(negedge CLK);
        end while (!rspValid);

        if (rspOp != e.op) begin
            reportMismatch("rspOp", int'(e.op), int'(rspOp));
        end
        if (e.exp == expWord && rspData != expData) begin
            reportMismatch("rspData", int'(expData), int'(rspData));
        end
        if (e.exp == expMac) begin
            for (int j = 0; j < numCols; j++) begin
                got = int'($signed(rspMac[j]));
                if (got != expCode[j]) begin
                    reportMismatch($sformatf("rspMac[%0d]", j), expCode[j], got);
                end
            end
        end

        // Back-pressure, everything must hold
        if (e.stall > 0) begin
            heldOp = rspOp;
            heldData = rspData;
            heldMac = rspMac;
            for (int c = 0; c < e.stall; c++) begin
                @(negedge CLK);
                if (!rspValid) begin
                    reportMismatch("rspValid", 1, int'(rspValid));
                end
                if (rspOp != heldOp) begin
                    reportMismatch("rspOp", int'(heldOp), int'(rspOp));
                end
                if (rspData != heldData) begin
                    reportMismatch("rspData", int'(heldData), int'(rspData));
                end
                if (rspMac != heldMac) begin
                    reportMismatch("rspMac", int'(heldMac), int'(rspMac));
                end
                if (reqReady) begin
                    reportMismatch("reqReady", 0, int'(reqReady));
                end
            end
            @(posedge CLK);
            rspReady <= 1'b1;
        end

        // Response transfers on this edge
        @(posedge CLK);
        @(negedge CLK);
        if (rspValid) begin
            reportMismatch("rspValid", 0, int'(rspValid));
        end

        testsRun++;
        if (errors == errBefore) begin
            $display("test %0d %s addr %0d ok", idx, curOp.name(), e.addr);
        end else begin
            testsFailed++;
            $display("test %0d %s addr %0d bad", idx, curOp.name(), e.addr);
        end
    endtask

    initial begin : mainSeq
        lfsrState = 16'd65;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        tableBuilt = 1'b0;
        rstN = 1'b0;
        reqValid = 1'b0;
        reqOp = opWrite;
        reqAddr = '0;
        reqData = '0;
        reqDrive = makeDrive(patZero);
        rspReady = 1'b1;

        buildTable();
        tableBuilt = 1'b1;

        repeat (8) @(posedge CLK);
        rstN <= 1'b1;

        // Idle state straight after reset
        @(negedge CLK);
        testsRun++;
        if (!reqReady) begin
            reportMismatch("reqReady", 1, int'(reqReady));
        end
        if (rspValid) begin
            reportMismatch("rspValid", 0, int'(rspValid));
        end
        if (errors == 0) begin
            $display("reset check ok");
        end else begin
            testsFailed++;
            $display("reset check bad");
        end

        for (int idx = 0; idx < stimTable.size(); idx++) begin
            runEntry(idx);
        end

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Budget of 20 cycles per table row plus reset
    initial begin : watchdog
        wait (tableBuilt);
        repeat (stimTable.size() * 20 + 18) @(posedge CLK);
        $display("Watchdog expired at t=%0t before the table finished", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cimTop_chk.sv ====
// Handshake assertions for the compute-in-memory top level
// Bound into every cimTop instance, watches the host ports only

`timescale 1ns/1ps
`default_nettype none

module cimTopChk #(
    parameter int numCols = 8,
    parameter int numAdcBits = 4
) (
    input logic                           CLK,
    input logic                           rstN,
    input logic                           reqValid,
    input logic                           reqReady,
    input logic                           rspValid,
    input logic                           rspReady,
    input logic [1:0]                     rspOp,
    input logic [numCols-1:0]             rspData,
    input logic [numCols*numAdcBits-1:0]  rspMac
);

    // rspValid goes high on the second edge after the accept edge
    rspLatency: assert property (@(posedge CLK) disable iff (!rstN)
        $rose(rspValid) |-> $past(reqValid && reqReady, 3))
        else $error("rspValid rose without an accept two edges earlier");

    // Stalled response keeps valid and payload
    rspHold: assert property (@(posedge CLK) disable iff (!rstN)
        (rspValid && !rspReady) |=>
            (rspValid && $stable(rspOp) && $stable(rspData) && $stable(rspMac)))
        else $error("response changed while rspReady was low");

    reqBlocked: assert property (@(posedge CLK) disable iff (!rstN)
        rspValid |-> !reqReady)
        else $error("reqReady high with a response pending");

endmodule

bind cimTop cimTopChk #(.numCols(numCols), .numAdcBits(numAdcBits)) chk (
    .CLK(CLK),
    .rstN(rstN),
    .reqValid(reqValid),
    .reqReady(reqReady),
    .rspValid(rspValid),
    .rspReady(rspReady),
    .rspOp(rspOp),
    .rspData(rspData),
    .rspMac(rspMac)
);

`default_nettype wire

// ==== cimTop.sv ====
// Top level of the compute-in-memory column design
// Sets the array geometry and connects the sequencer, row driver,
// column macro and ADC decoder behind the host request/response ports

`timescale 1ns/1ps
`default_nettype none

module cimTop import cimPkg::*; #(
    parameter int numRows = 16,
    parameter int numCols = 8,
    parameter int numAdcBits = 4,
    localparam int addrBits = $clog2(numRows),
    localparam int compCount = (2**numAdcBits) - 1
) (
    input  logic                                CLK,
    input  logic                                rstN,
    input  logic                                reqValid,
    output logic                                reqReady,
    input  cimOp                                reqOp,
    input  logic [addrBits-1:0]                 reqAddr,
    input  logic [numCols-1:0]                  reqData,
    input  rowDrive [numRows-1:0]               reqDrive,
    output logic                                rspValid,
    input  logic                                rspReady,
    output cimOp                                rspOp,
    output logic [numCols-1:0]                  rspData,
    output logic [numCols-1:0][numAdcBits-1:0]  rspMac
);

    phaseCtrl phase;
    logic rowEnable;
    logic [addrBits-1:0] curAddr;
    rowDrive [numRows-1:0] curDrive;
    logic [numCols-1:0] curData;
    logic [numRows-1:0] wordLine;
    logic [numRows-1:0] vdrSel;
    logic [numRows-1:0] vssSel;
    logic [numCols-1:0] saOut;
    logic [numCols*compCount-1:0] adcOut;
    logic [numCols-1:0][numAdcBits-1:0] macCode;

    cimSequencer #(.numRows(numRows), .numCols(numCols), .numAdcBits(numAdcBits)) uSeq (
        .CLK(CLK), .rstN(rstN),
        .reqValid(reqValid), .reqReady(reqReady), .reqOp(reqOp),
        .reqAddr(reqAddr), .reqData(reqData), .reqDrive(reqDrive),
        .saOut(saOut), .macCode(macCode),
        .phase(phase), .rowEnable(rowEnable),
        .curAddr(curAddr), .curDrive(curDrive), .curData(curData),
        .rspValid(rspValid), .rspReady(rspReady), .rspOp(rspOp),
        .rspData(rspData), .rspMac(rspMac)
    );

    rowDriver #(.numRows(numRows)) uRow (
        .CLK(CLK), .rstN(rstN), .enable(rowEnable),
        .addr(curAddr), .drive(curDrive),
        .wordLine(wordLine), .vdrSel(vdrSel), .vssSel(vssSel)
    );

    cimColumn #(.numRows(numRows), .numCols(numCols), .numAdcBits(numAdcBits)) uCol (
        .CLK(CLK), .rstN(rstN), .phase(phase),
        .wordLine(wordLine), .vdrSel(vdrSel), .vssSel(vssSel),
        .wrData(curData), .saOut(saOut), .adcOut(adcOut)
    );

    adcDecode #(.numCols(numCols), .numAdcBits(numAdcBits)) uAdc (
        .CLK(CLK), .rstN(rstN), .adcOut(adcOut), .macCode(macCode)
    );

endmodule

`default_nettype wire

// ==== cimSequencer.sv ====
// Command sequencer for the compute-in-memory column
// Accepts one host command at a time, strobes the macro phases for one
// cycle and returns a response two edges after acceptance
// reqReady stays low until that response has been taken

`timescale 1ns/1ps
`default_nettype none

module cimSequencer import cimPkg::*; #(
    parameter int numRows = 16,
    parameter int numCols = 8,
    parameter int numAdcBits = 4,
    localparam int addrBits = $clog2(numRows)
) (
    input  logic                                CLK,
    input  logic                                rstN,
    input  logic                                reqValid,
    output logic                                reqReady,
    input  cimOp                                reqOp,
    input  logic [addrBits-1:0]                 reqAddr,
    input  logic [numCols-1:0]                  reqData,
    input  rowDrive [numRows-1:0]               reqDrive,
    input  logic [numCols-1:0]                  saOut,
    input  logic [numCols-1:0][numAdcBits-1:0]  macCode,
    output phaseCtrl                            phase,
    output logic                                rowEnable,
    output logic [addrBits-1:0]                 curAddr,
    output rowDrive [numRows-1:0]               curDrive,
    output logic [numCols-1:0]                  curData,
    output logic                                rspValid,
    input  logic                                rspReady,
    output cimOp                                rspOp,
    output logic [numCols-1:0]                  rspData,
    output logic [numCols-1:0][numAdcBits-1:0]  rspMac
);

    typedef enum logic [1:0] {stIdle, stStrobe, stRespond} seqState;

    seqState state;
    cimOp opReg;
    logic [addrBits-1:0] addrReg;
    rowDrive [numRows-1:0] driveReg;
    logic [numCols-1:0] dataReg;
    logic [numCols-1:0] saReg;
    logic accept;
    logic rspFire;
    phaseCtrl phaseNext;

    assign reqReady = (state == stIdle);
    assign accept = reqValid && reqReady;
    assign rspFire = rspValid && rspReady;

    // Row driver loads on the accept edge, so feed it the live request
    assign rowEnable = accept;
    assign curAddr = (state == stIdle) ? reqAddr : addrReg;
    assign curDrive = (state == stIdle) ? reqDrive : driveReg;
    assign curData = dataReg;

    // Codes settle on E2 and hold until the next conversion
    assign rspMac = (rspOp == opMac) ? macCode : '0;

    // Strobe pattern per command
    always_comb begin
        phaseNext = '0;
        case (reqOp)
            opWrite: begin
                phaseNext.pch   = 1'b1;
                phaseNext.write = 1'b1;
            end
            opRead: begin
                phaseNext.pch  = 1'b1;
                phaseNext.saen = 1'b1;
            end
            opMac:   phaseNext.conv = 1'b1;
            default: phaseNext = '0;
        endcase
    end

    always_ff @(posedge CLK) begin : control
        if (!rstN) begin
            state    <= stIdle;
            phase    <= '0;
            rspValid <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (accept) begin
                        state <= stStrobe;
                        phase <= phaseNext;
                    end
                end
                // One strobe cycle, E0 to E1
                stStrobe: begin
                    state <= stRespond;
                    phase <= '0;
                end
                stRespond: begin
                    if (!rspValid) begin
                        rspValid <= 1'b1;
                    end else if (rspFire) begin
                        rspValid <= 1'b0;
                        state    <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin : payload
        if (accept) begin
            opReg    <= reqOp;
            addrReg  <= reqAddr;
            driveReg <= reqDrive;
            dataReg  <= reqData;
        end
        // Sense data is valid at the end of the strobe cycle
        if (state == stStrobe) begin
            saReg <= saOut;
        end
        if (state == stRespond && !rspValid) begin
            rspOp   <= opReg;
            rspData <= (opReg == opRead) ? saReg : '0;
        end
    end

endmodule

`default_nettype wire

// ==== adcDecode.sv ====
// Thermometer decoder for the column flash ADCs
// Counts the tripped comparators of each column and removes the mid-scale
// offset, giving one two's complement code per column, registered every cycle

`timescale 1ns/1ps
`default_nettype none

module adcDecode #(
    parameter int numCols = 8,
    parameter int numAdcBits = 4,
    localparam int compCount = (2**numAdcBits) - 1
) (
    input  logic                                 CLK,
    input  logic                                 rstN,
    input  logic [numCols*compCount-1:0]         adcOut,
    output logic [numCols-1:0][numAdcBits-1:0]   macCode
);

    localparam int codeHalf = 2**(numAdcBits-1);

    logic [numCols-1:0][compCount-1:0] compField;
    logic [numCols-1:0][numAdcBits:0] onesCount;
    logic [numCols-1:0][numAdcBits:0] codeDiff;

    assign compField = adcOut;

    always_comb begin
        for (int j = 0; j < numCols; j++) begin
            onesCount[j] = '0;
            for (int i = 0; i < compCount; i++) begin
                onesCount[j] = onesCount[j] + {{numAdcBits{1'b0}}, compField[j][i]};
            end
            // Mid-scale sits at codeHalf ones
            codeDiff[j] = onesCount[j] - (numAdcBits+1)'(codeHalf);
        end
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            macCode <= '0;
        end else begin
            for (int j = 0; j < numCols; j++) begin
                macCode[j] <= codeDiff[j][numAdcBits-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rowDriver.sv ====
// Row driver for the compute-in-memory column
// Loads a one-hot word line from the row address and the positive and
// negative select lines from the ternary input vector on the accept edge
// Lines stay up for one cycle, then drop while enable is low

`timescale 1ns/1ps
`default_nettype none

module rowDriver import cimPkg::*; #(
    parameter int numRows = 16,
    localparam int addrBits = $clog2(numRows)
) (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   enable,
    input  logic [addrBits-1:0]    addr,
    input  rowDrive [numRows-1:0]  drive,
    output logic [numRows-1:0]     wordLine,
    output logic [numRows-1:0]     vdrSel,
    output logic [numRows-1:0]     vssSel
);

    logic [numRows-1:0] wlNext;
    logic [numRows-1:0] vdrNext;
    logic [numRows-1:0] vssNext;

    // Address decode and per-row sign split
    always_comb begin
        wlNext = {{(numRows-1){1'b0}}, 1'b1} << addr;
        for (int i = 0; i < numRows; i++) begin
            vdrNext[i] = (drive[i] == drivePos);
            vssNext[i] = (drive[i] == driveNeg);
        end
    end

    // Registered lines keep the macro inputs glitch-free
    always_ff @(posedge CLK) begin
        if (!rstN || !enable) begin
            wordLine <= '0;
            vdrSel   <= '0;
            vssSel   <= '0;
        end else begin
            wordLine <= wlNext;
            vdrSel   <= vdrNext;
            vssSel   <= vssNext;
        end
    end

endmodule

`default_nettype wire

// ==== cimColumn.sv ====
// Behavioral model of the SRAM compute-in-memory column macro
// Stores one weight bit per row and column, senses a row on read and
// forms a bipolar MAC sum per column that a flash ADC turns into a
// thermometer code, registered on the conversion strobe

`timescale 1ns/1ps
`default_nettype none

module cimColumn import cimPkg::*; #(
    parameter int numRows = 16,
    parameter int numCols = 8,
    parameter int numAdcBits = 4,
    localparam int compCount = (2**numAdcBits) - 1
) (
    input  logic                          CLK,
    input  logic                          rstN,
    input  phaseCtrl                      phase,
    input  logic [numRows-1:0]            wordLine,
    input  logic [numRows-1:0]            vdrSel,
    input  logic [numRows-1:0]            vssSel,
    input  logic [numCols-1:0]            wrData,
    output logic [numCols-1:0]            saOut,
    output logic [numCols*compCount-1:0]  adcOut
);

    // ADC range, symmetric around the mid code
    localparam int codeHalf = 2**(numAdcBits-1);
    localparam int codeMax = codeHalf - 1;
    localparam int codeMin = -codeHalf;

    logic [numCols-1:0] mem [numRows];
    int colSum [numCols];
    int satCode [numCols];
    logic [numCols-1:0][compCount-1:0] compNext;

    // Cell array, written through the selected word line
    always_ff @(posedge CLK) begin : sramWrite
        if (phase.pch && phase.write) begin
            for (int i = 0; i < numRows; i++) begin
                if (wordLine[i]) begin
                    mem[i] <= wrData;
                end
            end
        end
    end

    // Sense amp output is not registered
    always_comb begin : senseRead
        saOut = '0;
        if (phase.pch && phase.saen) begin
            for (int i = 0; i < numRows; i++) begin
                if (wordLine[i]) begin
                    saOut = saOut | mem[i];
                end
            end
        end
    end

    // Bipolar accumulate on the MAC bitline
    always_comb begin : bipolarSum
        for (int j = 0; j < numCols; j++) begin
            colSum[j] = 0;
            for (int i = 0; i < numRows; i++) begin
                // Matching sign adds one, mismatch subtracts one
                if (vdrSel[i]) begin
                    colSum[j] = colSum[j] + (mem[i][j] ? 1 : -1);
                end else if (vssSel[i]) begin
                    colSum[j] = colSum[j] + (mem[i][j] ? -1 : 1);
                end
            end
            // Clip to what the ADC can resolve
            if (colSum[j] > codeMax) begin
                satCode[j] = codeMax;
            end else if (colSum[j] < codeMin) begin
                satCode[j] = codeMin;
            end else begin
                satCode[j] = colSum[j];
            end
            // Comparator i trips once the offset code passes it
            for (int i = 0; i < compCount; i++) begin
                compNext[j][i] = (satCode[j] + codeHalf) > i;
            end
        end
    end

    // Comparator bank latches on the conversion strobe
    always_ff @(posedge CLK) begin : adcLatch
        if (!rstN) begin
            adcOut <= '0;
        end else if (phase.conv) begin
            adcOut <= compNext;
        end
    end

endmodule

`default_nettype wire

// ==== cimPkg.sv ====
// Shared types for the compute-in-memory column design
// Holds the host command code, the per-row input drive code and the
// phase-strobe bundle that the sequencer sends to the column macro
// Modules pull these in with a wildcard import in their header

`default_nettype none

package cimPkg;

    // Host command carried on reqOp and echoed on rspOp
    typedef enum logic [1:0] {
        opWrite = 2'd0,
        opRead  = 2'd1,
        opMac   = 2'd2
    } cimOp;

    // Ternary input value for one row during a MAC
    typedef enum logic [1:0] {
        driveZero = 2'd0,
        drivePos  = 2'd1,
        driveNeg  = 2'd2
    } rowDrive;

    // Macro phase strobes, one bit each
    typedef struct packed {
        logic pch;    // Bitline precharge
        logic write;  // Write driver enable
        logic saen;   // Sense amplifier enable
        logic conv;   // Flash ADC conversion
    } phaseCtrl;

endpackage

`default_nettype wire
